// ==== hw/nnTypesPkg.sv ====
package nnTypesPkg;

	// every activation is a signed 32-bit word
	localparam int ActBits = 32;

	// inputs and outputs use 13 fraction bits, so 8192 stands for 1.0
	localparam int FracBits = 13;

	// the ReLU keeps this many bits of the sum, starting at FracBits
	localparam int OutBits = 16;

	typedef logic signed [ActBits-1:0] activation_t;

	// in0 sits in the low word, so the struct lines up with an array indexed from 0
	typedef struct packed {
		activation_t in3;
		activation_t in2;
		activation_t in1;
		activation_t in0;
	} inputVector_t;

	typedef struct packed {
		activation_t out1;
		activation_t out0;
	} outputVector_t;

endpackage

// ==== hw/nnWeightsPkg.sv ====
package nnWeightsPkg;

	import nnTypesPkg::*;

	localparam int InputCount = 4;
	localparam int HiddenCount = 3;
	localparam int OutputCount = 2;

	// weights have 13 fraction bits, like the activations they multiply
	localparam activation_t [0:HiddenCount-1][0:InputCount-1] hiddenWeights = '{
		'{
			4096,
			-2458,
			1638,
			819
		},
		'{
			-1229,
			3277,
			2048,
			-4096
		},
		'{
			2867,
			1024,
			-3686,
			1434
		}
	};

	// biases are added straight to the products, so they carry 26 fraction bits
	localparam activation_t [0:HiddenCount-1] hiddenBias = '{
		33554432,
		-16777216,
		20132659
	};

	localparam activation_t [0:OutputCount-1][0:HiddenCount-1] outputWeights = '{
		'{
			3686,
			-2048,
			2458
		},
		'{
			-1638,
			2867,
			1229
		}
	};

	localparam activation_t [0:OutputCount-1] outputBias = '{
		13421773,
		-6710886
	};

endpackage

// ==== hw/neuron.sv ====
`timescale 1ns/1ps

module neuron
	import nnTypesPkg::*;
#(
	parameter int InputCount = 4,
	parameter activation_t [0:InputCount-1] Weights = '0,
	parameter activation_t Bias = '0
)
(
	input logic clk,
	input logic reset,
	input activation_t [InputCount-1:0] inputs,
	output activation_t result
);

	// each product keeps only its low 32 bits, so large operands wrap around
	activation_t [InputCount-1:0] products;
	activation_t macSum;
	activation_t sum;
	activation_t rescaled;

	if (InputCount < 1)
	begin : badInputCount
		$error("neuron needs at least one input");
	end

	if (FracBits + OutBits > ActBits)
	begin : badRescale
		$error("rescaled field does not fit in an activation word");
	end

	// a negative sum clips to zero, otherwise the field above the fraction bits is kept
	function automatic activation_t reluRescale(activation_t value);
		activation_t scaled;
		scaled = '0;
		if (!value[ActBits-1])
		begin
			scaled[OutBits-1:0] = value[FracBits +: OutBits];
		end
		return scaled;
	endfunction

	always_comb
	begin
		for (int i = 0; i < InputCount; i++)
		begin
			products[i] = inputs[i] * Weights[i];
		end
	end

	always_comb
	begin
		macSum = Bias;
		for (int i = 0; i < InputCount; i++)
		begin
			macSum = macSum + products[i];
		end
	end

	assign rescaled = reluRescale(sum);

	// sum is the second pipeline stage of a layer, result the third
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sum <= '0;
			result <= '0;
		end
		else
		begin
			sum <= macSum;
			result <= rescaled;
		end
	end

	// the output field is only OutBits wide, nothing may show above it
	upperBitsClear: assert property (
		@(posedge clk) disable iff (reset)
		result[ActBits-1:OutBits] == '0
	);

	// a negative sum must come out as zero one edge later
	negativeGivesZero: assert property (
		@(posedge clk) disable iff (reset)
		sum[ActBits-1] |=> result == '0
	);

endmodule

// ==== hw/denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer
	import nnTypesPkg::*;
#(
	parameter int InputCount = 4,
	parameter int NeuronCount = 3,
	parameter activation_t [0:NeuronCount-1][0:InputCount-1] Weights = '0,
	parameter activation_t [0:NeuronCount-1] Bias = '0
)
(
	input logic clk,
	input logic reset,
	input activation_t [InputCount-1:0] inputs,
	output activation_t [NeuronCount-1:0] results
);

	// one capture register for the whole layer, all neurons read the same copy
	activation_t [InputCount-1:0] captured;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			captured <= '0;
		end
		else
		begin
			captured <= inputs;
		end
	end

	for (genvar n = 0; n < NeuronCount; n++)
	begin : neurons
		neuron #(
			.InputCount(InputCount),
			.Weights(Weights[n]),
			.Bias(Bias[n])
		) node (
			.clk(clk),
			.reset(reset),
			.inputs(captured),
			.result(results[n])
		);
	end

	capturedClearedByReset: assert property (
		@(posedge clk)
		reset |=> captured == '0
	);

endmodule

// ==== hw/mlpInference.sv ====
`timescale 1ns/1ps

module mlpInference
	import nnTypesPkg::*;
	import nnWeightsPkg::*;
(
	input logic clk,
	input logic reset,
	input inputVector_t features,
	output outputVector_t scores
);

	activation_t [InputCount-1:0] featureArray;
	activation_t [HiddenCount-1:0] hiddenArray;
	activation_t [OutputCount-1:0] scoreArray;

	always_comb
	begin
		featureArray[0] = features.in0;
		featureArray[1] = features.in1;
		featureArray[2] = features.in2;
		featureArray[3] = features.in3;
	end

	// each layer adds three edges, so a vector reaches scores six edges after it is sampled
	denseLayer #(
		.InputCount(InputCount),
		.NeuronCount(HiddenCount),
		.Weights(hiddenWeights),
		.Bias(hiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(featureArray),
		.results(hiddenArray)
	);

	denseLayer #(
		.InputCount(HiddenCount),
		.NeuronCount(OutputCount),
		.Weights(outputWeights),
		.Bias(outputBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenArray),
		.results(scoreArray)
	);

	always_comb
	begin
		scores.out0 = scoreArray[0];
		scores.out1 = scoreArray[1];
	end

endmodule

// ==== sim/mlpInferenceTb.sv ====
`timescale 1ns/1ps

module mlpInferenceTb
	import nnTypesPkg::*;
();

	localparam int Latency = 6;
	localparam int ResetCycles = 2;
	localparam int TimeoutMargin = 20;
	localparam int NameChars = 24;
	localparam string PatternFile = "sim/mlpPatterns.txt";

	typedef struct packed {
		logic [8*NameChars-1:0] name;
		logic resetFlag;
		inputVector_t features;
		outputVector_t expected;
	} pattern_t;

	// a driven pattern waiting for its scores to reach the outputs
	typedef struct packed {
		int unsigned index;
		int unsigned due;
	} pending_t;

	logic clk;
	logic reset;
	inputVector_t features;
	outputVector_t scores;

	pattern_t patterns[$];
	pending_t pending[$];

	int unsigned cycle = 0;
	int unsigned cycleLimit = 0;
	int passCount = 0;
	int failCount = 0;
	int loadErrors = 0;

	mlpInference DUT (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores)
	);

	initial
	begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycleLimit != 0 && cycle >= cycleLimit)
		begin
			$display("run timed out after %0d cycles with %0d results outstanding",
				cycle, pending.size());
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic loadPatterns();
		int fd;
		int fields;
		string line;
		logic [8*NameChars-1:0] nameText;
		logic flag;
		activation_t w0;
		activation_t w1;
		activation_t w2;
		activation_t w3;
		activation_t e0;
		activation_t e1;
		pattern_t entry;
		fd = $fopen(PatternFile, "r");
		if (fd == 0)
		begin
			$display("cannot open pattern file %s", PatternFile);
			loadErrors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			// comment and blank lines carry no test
			if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r")
			begin
				continue;
			end
			nameText = '0;
			fields = $sscanf(line, "%s %h %h %h %h %h %h %h",
				nameText, flag, w0, w1, w2, w3, e0, e1);
			if (fields != 8)
			begin
				$display("pattern line could not be parsed: %s", line);
				loadErrors++;
				continue;
			end
			entry.name = nameText;
			entry.resetFlag = flag;
			entry.features.in0 = w0;
			entry.features.in1 = w1;
			entry.features.in2 = w2;
			entry.features.in3 = w3;
			entry.expected.out0 = e0;
			entry.expected.out1 = e1;
			patterns.push_back(entry);
		end
		$fclose(fd);
	endtask

	task automatic compareValue(input logic [8*NameChars-1:0] name, input string field,
		input activation_t expected, input activation_t actual, inout bit ok);
		if (actual !== expected)
		begin
			$display("error %0s %s: expected %08h, actual %08h", name, field, expected, actual);
			ok = 1'b0;
		end
	endtask

	// finish every test whose scores are due in this cycle
	task automatic checkDueResults();
		pending_t head;
		bit ok;
		while (pending.size() > 0 && pending[0].due == cycle)
		begin
			head = pending.pop_front();
			ok = 1'b1;
			compareValue(patterns[head.index].name, "out0",
				patterns[head.index].expected.out0, scores.out0, ok);
			compareValue(patterns[head.index].name, "out1",
				patterns[head.index].expected.out1, scores.out1, ok);
			if (ok)
			begin
				passCount++;
				$display("pass %0s", patterns[head.index].name);
			end
			else
			begin
				failCount++;
				$display("fail %0s", patterns[head.index].name);
			end
		end
	endtask

	initial
	begin
		pending_t entry;
		reset = 1'b1;
		features = '0;
		loadPatterns();
		cycleLimit = patterns.size() + ResetCycles + Latency + TimeoutMargin;
		repeat (ResetCycles) @(posedge clk);
		#2;
		reset = 1'b0;
		for (int i = 0; i < patterns.size(); i++)
		begin
			checkDueResults();
			reset = patterns[i].resetFlag;
			features = patterns[i].features;
			entry.index = i;
			entry.due = cycle + Latency;
			pending.push_back(entry);
			@(posedge clk);
			#2;
		end
		reset = 1'b0;
		features = '0;
		while (pending.size() > 0)
		begin
			checkDueResults();
			if (pending.size() > 0)
			begin
				@(posedge clk);
				#2;
			end
		end
		$display("%0d tests passed, %0d tests failed, %0d pattern load errors",
			passCount, failCount, loadErrors);
		if (failCount == 0 && loadErrors == 0 && passCount > 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== sim/mlpPatterns.txt ====
# columns: test name, reset flag, in0 in1 in2 in3, expected out0 out1, all in hex
# the expected scores are the ones on the outputs six cycles after the line is driven
# zero inputs give the bias chain
idle_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
idle_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
idle_2 0 00000000 00000000 00000000 00000000 0000107a 00000000
idle_3 0 00000000 00000000 00000000 00000000 0000107a 00000000
idle_4 0 00000000 00000000 00000000 00000000 0000107a 00000000
idle_5 0 00000000 00000000 00000000 00000000 0000107a 00000000
idle_6 0 00000000 00000000 00000000 00000000 0000107a 00000000
idle_7 0 00000000 00000000 00000000 00000000 0000107a 00000000
# one vector between zeros
single_lead_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
single_lead_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
single_lead_2 0 00000000 00000000 00000000 00000000 0000107a 00000000
single_a 0 00002000 00000000 00000000 00000000 00001b09 00000000
single_tail_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
single_tail_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
single_tail_2 0 00000000 00000000 00000000 00000000 0000107a 00000000
single_tail_3 0 00000000 00000000 00000000 00000000 0000107a 00000000
single_tail_4 0 00000000 00000000 00000000 00000000 0000107a 00000000
# one vector per cycle keeps six in flight
b2b_a 0 00002000 00000000 00000000 00000000 00001b09 00000000
b2b_b 0 00000000 00004000 00000000 00000000 00000747 00000599
b2b_c 0 ffffc000 00004000 00000000 00000000 00000000 00000652
b2b_d 0 00028000 00000000 00000000 00000000 0000707b 00000fd8
b2b_b2 0 00000000 00004000 00000000 00000000 00000747 00000599
b2b_a2 0 00002000 00000000 00000000 00000000 00001b09 00000000
b2b_d2 0 00028000 00000000 00000000 00000000 0000707b 00000fd8
b2b_c2 0 ffffc000 00004000 00000000 00000000 00000000 00000652
b2b_a3 0 00002000 00000000 00000000 00000000 00001b09 00000000
b2b_b3 0 00000000 00004000 00000000 00000000 00000747 00000599
b2b_gap_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
b2b_gap_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
# negative sums clip to zero, the large hidden sum of d wraps above bit 28
neg_lead 0 00000000 00000000 00000000 00000000 0000107a 00000000
neg_c 0 ffffc000 00004000 00000000 00000000 00000000 00000652
neg_gap_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
neg_gap_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
big_d 0 00028000 00000000 00000000 00000000 0000707b 00000fd8
big_gap_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
big_gap_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
big_d_again 0 00028000 00000000 00000000 00000000 0000707b 00000fd8
neg_c_after 0 ffffc000 00004000 00000000 00000000 00000000 00000652
sign_tail_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
sign_tail_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
# reset mid-stream, the five vectors before it are lost
rst_pre_0 0 00000000 00004000 00000000 00000000 00000747 00000599
rst_pre_1 0 00002000 00000000 00000000 00000000 00000000 00000000
rst_pre_2 0 00028000 00000000 00000000 00000000 00000000 00000000
rst_pre_3 0 ffffc000 00004000 00000000 00000000 00000666 00000000
rst_pre_4 0 00000000 00004000 00000000 00000000 00000666 00000000
rst_pre_5 0 00002000 00000000 00000000 00000000 00000666 00000000
rst_hit 1 00000000 00000000 00000000 00000000 0000107a 00000000
rst_fill_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
rst_fill_b 0 00000000 00004000 00000000 00000000 00000747 00000599
rst_fill_d 0 00028000 00000000 00000000 00000000 0000707b 00000fd8
rst_fill_a 0 00002000 00000000 00000000 00000000 00001b09 00000000
rst_fill_c 0 ffffc000 00004000 00000000 00000000 00000000 00000652
rst_tail_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
rst_tail_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
rst_tail_2 0 00000000 00000000 00000000 00000000 0000107a 00000000
# mixed stream with zeros between some vectors
mix_d 0 00028000 00000000 00000000 00000000 0000707b 00000fd8
mix_zero_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
mix_b 0 00000000 00004000 00000000 00000000 00000747 00000599
mix_c 0 ffffc000 00004000 00000000 00000000 00000000 00000652
mix_zero_1 0 00000000 00000000 00000000 00000000 0000107a 00000000
mix_a 0 00002000 00000000 00000000 00000000 00001b09 00000000
mix_a_again 0 00002000 00000000 00000000 00000000 00001b09 00000000
mix_zero_2 0 00000000 00000000 00000000 00000000 0000107a 00000000
mix_c_again 0 ffffc000 00004000 00000000 00000000 00000000 00000652
mix_d_again 0 00028000 00000000 00000000 00000000 0000707b 00000fd8
mix_b_again 0 00000000 00004000 00000000 00000000 00000747 00000599
mix_zero_3 0 00000000 00000000 00000000 00000000 0000107a 00000000
mix_end_0 0 00000000 00000000 00000000 00000000 0000107a 00000000
mix_end_1 0 00000000 00000000 00000000 00000000 0000107a 00000000

// ==== files.f ====
hw/nnTypesPkg.sv
hw/nnWeightsPkg.sv
hw/neuron.sv
hw/denseLayer.sv
hw/mlpInference.sv
sim/mlpInferenceTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the fail message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_NAME=mlpInferenceSim
LOG_FILE=sim.log

verilator --binary --timing --assert \
	-f files.f \
	--top-module mlpInferenceTb \
	-Mdir "$BUILD_DIR" \
	-o "$SIM_NAME"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_NAME" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$LOG_FILE"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "Test OK" "$LOG_FILE"; then
	echo "simulation ended without a pass message"
	exit 1
fi

exit 0
